// ==== design/gng_pkg.sv ====
`default_nettype none

package gng_pkg;

    // --------------------
    // uniform source
    // --------------------

    // one uniform word, two 32-bit generators side by side
    localparam int URNG_W = 64;

    // leading-zero count over the 63 bits below the sign bit
    localparam int LZ_W = 6;

    // --------------------
    // fixed-point formats
    // --------------------

    // interpolation offset, b operand of the multiply-add
    localparam int X_W = 18;

    // output sample, signed s4.11
    localparam int SAMPLE_W      = 16;
    localparam int SAMPLE_FRAC_W = 11;

    // ce advances from uniform word to registered sample
    // urng 1, segment 1, rom 1, two multiply-adds 3 each, rounding 1
    localparam int LATENCY = 10;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire

// ==== design/gng_coef_pkg.sv ====
`default_nettype none

package gng_coef_pkg;

    // 8 leading-zero groups times 4 sub-segments
    localparam int SEG_N  = 32;
    localparam int SEG_AW = $clog2(SEG_N);

    // coefficient widths
    // c2 matches the adder width of the multiply-add
    localparam int C0_W = 16;
    localparam int C1_W = 18;
    localparam int C2_W = 37;

    // rom word layout, c0 in the low bits
    localparam int COEF_W = C0_W + C1_W + C2_W;
    localparam int C0_LSB = 0;
    localparam int C1_LSB = C0_LSB + C0_W;
    localparam int C2_LSB = C1_LSB + C1_W;

    // one hex word per segment
    localparam string COEF_FILE = "design/gng_coef.hex";

    typedef logic [COEF_W-1:0] coef_word_t;

endpackage

`default_nettype wire

// ==== design/gng_urng.sv ====
`default_nettype none

module gng_urng import gng_pkg::*; #(
    parameter logic [31:0] SEED0 = 32'hf0d2_c3a1,
    parameter logic [31:0] SEED1 = 32'h1b6e_95c7,
    parameter logic [31:0] SEED2 = 32'h8a37_e04d,
    parameter logic [31:0] SEED3 = 32'h4c91_5f2b
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              ce,
    output logic [URNG_W-1:0] u
);

    // forced into every loaded state so no component starts in its dead state
    localparam logic [31:0] SEED_FIX = 32'h0000_0100;

    // generator a feeds u[63:32], generator b feeds u[31:0]
    logic [31:0] a1, a2, a3;
    logic [31:0] b1, b2, b3;
    logic [31:0] a1_nxt, a2_nxt, a3_nxt;
    logic [31:0] b1_nxt, b2_nxt, b3_nxt;

    // one taus88 component step
    function automatic logic [31:0] taus_step(
        input logic [31:0] s,
        input logic [31:0] mask,
        input int          q,
        input int          k,
        input int          sh
    );
        logic [31:0] fb;
        fb = ((s << q) ^ s) >> k;
        return ((s & mask) << sh) ^ fb;
    endfunction

    // standard constants, (q, k, s) = (13,19,12) (2,25,4) (3,11,17)
    always_comb begin
        a1_nxt = taus_step(a1, 32'hffff_fffe, 13, 19, 12);
        a2_nxt = taus_step(a2, 32'hffff_fff8, 2, 25, 4);
        a3_nxt = taus_step(a3, 32'hffff_fff0, 3, 11, 17);
        b1_nxt = taus_step(b1, 32'hffff_fffe, 13, 19, 12);
        b2_nxt = taus_step(b2, 32'hffff_fff8, 2, 25, 4);
        b3_nxt = taus_step(b3, 32'hffff_fff0, 3, 11, 17);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // generator b reuses inverted seeds
            a1 <= SEED0 | SEED_FIX;
            a2 <= SEED1 | SEED_FIX;
            a3 <= SEED2 | SEED_FIX;
            b1 <= SEED3 | SEED_FIX;
            b2 <= ~SEED0 | SEED_FIX;
            b3 <= ~SEED1 | SEED_FIX;
            u  <= '0;
        end else if (ce) begin
            a1 <= a1_nxt;
            a2 <= a2_nxt;
            a3 <= a3_nxt;
            b1 <= b1_nxt;
            b2 <= b2_nxt;
            b3 <= b3_nxt;
            // output taken from the freshly stepped state
            u  <= {a1_nxt ^ a2_nxt ^ a3_nxt, b1_nxt ^ b2_nxt ^ b3_nxt};
        end
    end

endmodule

`default_nettype wire

// ==== design/gng_segment.sv ====
`default_nettype none

module gng_segment import gng_pkg::*, gng_coef_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              ce,
    input  logic [URNG_W-1:0] u,
    output logic [SEG_AW-1:0] seg_addr,
    output logic [X_W-1:0]    x_off,
    output logic              neg
);

    // magnitude bits below the sign
    localparam int MAG_W  = URNG_W - 1;
    // upper address bits come from the saturated count
    localparam int HI_W   = SEG_AW - 2;
    localparam int LZ_MAX = 2**HI_W - 1;

    logic [LZ_W-1:0]  lz;
    logic [HI_W-1:0]  lz_sat;
    logic [MAG_W-1:0] mag_sh;

    // priority count, highest set bit wins
    // all zero gives MAG_W
    always_comb begin
        lz = LZ_W'(MAG_W);
        for (int i = 0; i < MAG_W; i++) begin
            if (u[i]) begin
                lz = LZ_W'(MAG_W - 1 - i);
            end
        end
    end

    // deep tail segments share the last group
    assign lz_sat = (lz > LZ_W'(LZ_MAX)) ? HI_W'(LZ_MAX) : lz[HI_W-1:0];

    // leading one lands at the top bit, unless saturated
    assign mag_sh = u[MAG_W-1:0] << lz_sat;

    always_ff @(posedge clk) begin
        if (reset) begin
            seg_addr <= '0;
            x_off    <= '0;
            neg      <= 1'b0;
        end else if (ce) begin
            // two bits after the leading one pick the sub-segment
            seg_addr <= {lz_sat, mag_sh[MAG_W-2 -: 2]};
            // next 18 bits are the offset inside the segment
            x_off    <= mag_sh[MAG_W-4 -: X_W];
            neg      <= u[URNG_W-1];
        end
    end

endmodule

`default_nettype wire

// ==== design/gng_coef_rom.sv ====
`default_nettype none

module gng_coef_rom import gng_pkg::*, gng_coef_pkg::*; (
    input  logic              clk,
    input  logic              ce,
    input  logic [SEG_AW-1:0] seg_addr,
    input  logic [X_W-1:0]    x_off,
    input  logic              neg,
    output coef_word_t        coef,
    output logic [X_W-1:0]    x_d,
    output logic              neg_d
);

    // one word per segment, {c2, c1, c0}
    coef_word_t rom [SEG_N];

    initial begin
        $readmemh(COEF_FILE, rom);
    end

    // synchronous read
    // offset and sign ride along so they meet their coefficients
    always_ff @(posedge clk) begin
        if (ce) begin
            coef  <= rom[seg_addr];
            x_d   <= x_off;
            neg_d <= neg;
        end
    end

endmodule

`default_nettype wire

// ==== design/gng_smul_sadd.sv ====
`default_nettype none

module gng_smul_sadd #(
    parameter int A_W = 16,
    parameter int B_W = 18,
    parameter int C_W = 37
) (
    input  logic           clk,
    input  logic           ce,
    input  logic [A_W-1:0] a,
    input  logic [B_W-1:0] b,
    input  logic [C_W-1:0] c,
    output logic [C_W:0]   p
);

    // p = c + a * b, all two's complement, three ce advances
    logic signed [A_W-1:0]     a_q;
    logic signed [B_W-1:0]     b_q;
    logic signed [C_W-1:0]     c_q;
    logic signed [C_W-1:0]     c_qq;
    logic signed [A_W+B_W-1:0] prod_q;
    logic signed [C_W:0]       sum_q;

    always_ff @(posedge clk) begin
        if (ce) begin
            // stage 1, operand registers
            a_q    <= a;
            b_q    <= b;
            c_q    <= c;
            // stage 2, full-width product
            // addend delayed so it stays with its product
            prod_q <= a_q * b_q;
            c_qq   <= c_q;
            // stage 3, sum one bit wider than c
            sum_q  <= c_qq + prod_q;
        end
    end

    assign p = sum_q;

endmodule

`default_nettype wire

// ==== design/gng_poly.sv ====
`default_nettype none

module gng_poly import gng_pkg::*, gng_coef_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           ce,
    input  coef_word_t     coef,
    input  logic [X_W-1:0] x_d,
    input  logic           neg_d,
    output sample_t        sample,
    output logic           valid_out
);

    // --------------------
    // formats and delays
    // --------------------
    localparam int P_W       = C2_W + 1;
    // p2 binary point, sample keeps SAMPLE_FRAC_W of it
    localparam int P2_FRAC_W = 29;
    localparam int OUT_SH    = P2_FRAC_W - SAMPLE_FRAC_W;
    localparam int RES_W     = P_W - OUT_SH;
    localparam int MADD_DLY  = 3;
    localparam int NEG_DLY   = 2 * MADD_DLY;
    localparam int CNT_W     = $clog2(LATENCY + 1);

    // half an output lsb, added in the second multiply-add
    localparam logic [C2_W-1:0] ROUND_K = C2_W'(1) << (OUT_SH - 1);
    // symmetric clip, most negative code never produced
    localparam logic signed [RES_W-1:0] SAT_POS = RES_W'(2**(SAMPLE_W-1) - 1);
    localparam logic signed [RES_W-1:0] SAT_NEG = -SAT_POS;

    logic [C0_W-1:0]    c0_pipe [MADD_DLY];
    logic [NEG_DLY-1:0] neg_pipe;
    logic [C2_W:0]      p1;
    logic [C2_W:0]      p2;
    logic signed [RES_W-1:0] res;
    logic signed [RES_W-1:0] res_sat;
    sample_t            mag;
    logic [CNT_W-1:0]   fill_cnt;

    // x is taken as a signed offset around the segment centre
    // c2 is stored at the product scale and enters unshifted
    // p1 = c1 * x + c2
    gng_smul_sadd #(.A_W(C1_W), .B_W(X_W), .C_W(C2_W)) madd1_inst (
        .clk (clk),
        .ce  (ce),
        .a   (coef[C1_LSB +: C1_W]),
        .b   (x_d),
        .c   (coef[C2_LSB +: C2_W]),
        .p   (p1)
    );

    // p2 = c0 * p1[37:20] + ROUND_K
    gng_smul_sadd #(.A_W(C0_W), .B_W(X_W), .C_W(C2_W)) madd2_inst (
        .clk (clk),
        .ce  (ce),
        .a   (c0_pipe[MADD_DLY-1]),
        .b   (p1[P_W-1 -: X_W]),
        .c   (ROUND_K),
        .p   (p2)
    );

    // c0 waits out madd1, sign waits out both
    always_ff @(posedge clk) begin
        if (ce) begin
            c0_pipe[0] <= coef[C0_LSB +: C0_W];
            for (int i = 1; i < MADD_DLY; i++) begin
                c0_pipe[i] <= c0_pipe[i-1];
            end
            neg_pipe <= {neg_pipe[NEG_DLY-2:0], neg_d};
        end
    end

    // --------------------
    // round and clip
    // --------------------
    // drop OUT_SH bits, rounding already added above
    assign res = p2[P_W-1:OUT_SH];

    always_comb begin
        if (res > SAT_POS) begin
            res_sat = SAT_POS;
        end else if (res < SAT_NEG) begin
            res_sat = SAT_NEG;
        end else begin
            res_sat = res;
        end
        mag = res_sat[SAMPLE_W-1:0];
    end

    // fill counter stops at LATENCY
    // sample only loads once the pipe holds real data
    always_ff @(posedge clk) begin
        if (reset) begin
            fill_cnt  <= '0;
            valid_out <= 1'b0;
            sample    <= '0;
        end else begin
            valid_out <= 1'b0;
            if (ce) begin
                if (fill_cnt != CNT_W'(LATENCY)) begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
                if (fill_cnt >= CNT_W'(LATENCY - 1)) begin
                    valid_out <= 1'b1;
                    sample    <= neg_pipe[NEG_DLY-1] ? -mag : mag;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/gng_top.sv ====
`default_nettype none

module gng_top import gng_pkg::*, gng_coef_pkg::*; #(
    parameter logic [31:0] SEED0 = 32'hf0d2_c3a1,
    parameter logic [31:0] SEED1 = 32'h1b6e_95c7,
    parameter logic [31:0] SEED2 = 32'h8a37_e04d,
    parameter logic [31:0] SEED3 = 32'h4c91_5f2b
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    ce,
    output sample_t sample,
    output logic    valid_out
);

    // stage links
    logic [URNG_W-1:0] u;
    logic [SEG_AW-1:0] seg_addr;
    logic [X_W-1:0]    x_off;
    logic              neg;
    coef_word_t        coef;
    logic [X_W-1:0]    x_d;
    logic              neg_d;

    // stage 1, uniform bits
    gng_urng #(
        .SEED0 (SEED0),
        .SEED1 (SEED1),
        .SEED2 (SEED2),
        .SEED3 (SEED3)
    ) urng_inst (
        .clk   (clk),
        .reset (reset),
        .ce    (ce),
        .u     (u)
    );

    // stage 2, segment select
    gng_segment segment_inst (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .u        (u),
        .seg_addr (seg_addr),
        .x_off    (x_off),
        .neg      (neg)
    );

    // stage 3, coefficient lookup
    gng_coef_rom coef_rom_inst (
        .clk      (clk),
        .ce       (ce),
        .seg_addr (seg_addr),
        .x_off    (x_off),
        .neg      (neg),
        .coef     (coef),
        .x_d      (x_d),
        .neg_d    (neg_d)
    );

    // stages 4 to 6, evaluation and output
    gng_poly poly_inst (
        .clk       (clk),
        .reset     (reset),
        .ce        (ce),
        .coef      (coef),
        .x_d       (x_d),
        .neg_d     (neg_d),
        .sample    (sample),
        .valid_out (valid_out)
    );

endmodule

`default_nettype wire

// ==== dv/gng_chk.sv ====
`default_nettype none

module gng_chk import gng_pkg::*; (
    input wire logic    clk,
    input wire logic    reset,
    input wire logic    ce,
    input wire sample_t sample,
    input wire logic    valid_out
);

    // a stalled edge never produces a sample
    valid_after_stall: assert property (
        @(posedge clk) disable iff (reset) !$past(ce) |-> !valid_out
    ) else $error("valid_out high after an edge with ce low");

    // reset clears valid_out on the next edge
    valid_in_reset: assert property (
        @(posedge clk) $past(reset) |-> !valid_out
    ) else $error("valid_out high after reset edge");

    // symmetric saturation excludes the most negative code
    sample_not_min: assert property (
        @(posedge clk) valid_out |-> (sample != {1'b1, {(SAMPLE_W-1){1'b0}}})
    ) else $error("valid sample at most negative code");

endmodule

bind gng_poly gng_chk chk_inst (
    .clk       (clk),
    .reset     (reset),
    .ce        (ce),
    .sample    (sample),
    .valid_out (valid_out)
);

`default_nettype wire

// ==== dv/gng_tb.sv ====
`default_nettype none

module gng_tb import gng_pkg::*; ();

    localparam logic [31:0] SEED0 = 32'hf0d2_c3a1;
    localparam logic [31:0] SEED1 = 32'h1b6e_95c7;
    localparam logic [31:0] SEED2 = 32'h8a37_e04d;
    localparam logic [31:0] SEED3 = 32'h4c91_5f2b;
    localparam int TIMEOUT = 400;
    localparam int STALL_N = 30;

    logic    clk;
    logic    reset;
    logic    ce;
    sample_t sample;
    logic    valid_out;

    // expected magnitudes from the stimulus file
    sample_t exp_mag [$];
    int      n_valid;
    logic    saw_pos;
    logic    saw_neg;
    logic [31:0] rnd;
    // sign model, the upper generator only
    logic [31:0] s1, s2, s3;

    gng_top #(
        .SEED0 (SEED0),
        .SEED1 (SEED1),
        .SEED2 (SEED2),
        .SEED3 (SEED3)
    ) gng_top_inst (
        .clk       (clk),
        .reset     (reset),
        .ce        (ce),
        .sample    (sample),
        .valid_out (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sample(input sample_t act, input sample_t exp, input string name);
        if (act !== exp) begin
            $display("** Error: %s = %h, expected %h", name, act, exp);
            abort_run("sample mismatch");
        end
    endtask

    task automatic check_valid(input logic act, input logic exp, input string name);
        if (act !== exp) begin
            $display("** Error: %s = %h, expected %h", name, act, exp);
            abort_run("valid mismatch");
        end
    endtask

    // taus88 step of the three upper components, returns u[63]
    task automatic next_sign(output logic sgn);
        logic [31:0] t;
        t  = ((s1 << 13) ^ s1) >> 19;
        s1 = ((s1 & 32'hffff_fffe) << 12) ^ t;
        t  = ((s2 << 2) ^ s2) >> 25;
        s2 = ((s2 & 32'hffff_fff8) << 4) ^ t;
        t  = ((s3 << 3) ^ s3) >> 11;
        s3 = ((s3 & 32'hffff_fff0) << 17) ^ t;
        sgn = s1[31] ^ s2[31] ^ s3[31];
    endtask

    task automatic load_stim();
        int    fd;
        string line;
        sample_t v;
        fd = $fopen("dv/gng_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open dv/gng_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h", v) == 1) begin
                    exp_mag.push_back(v);
                end
            end
        end
        $fclose(fd);
    endtask

    // checks at the current falling edge, then drives ce and moves on
    // once the pipe is full valid_out follows the ce of the last edge
    task automatic tick(input logic ce_next);
        logic    sgn;
        sample_t exp;
        check_valid(valid_out, ce, "valid_out");
        if (valid_out) begin
            if (n_valid >= exp_mag.size()) begin
                abort_run("more valid samples than stimulus lines");
            end
            if (sample == sample_t'(16'h8000)) begin
                abort_run("sample outside saturated range");
            end
            next_sign(sgn);
            exp = sgn ? -exp_mag[n_valid] : exp_mag[n_valid];
            check_sample(sample, exp, "sample");
            if (sample[SAMPLE_W-1]) begin
                saw_neg = 1'b1;
            end else begin
                saw_pos = 1'b1;
            end
            n_valid++;
        end
        ce = ce_next;
        @(negedge clk);
    endtask

    // --------------------
    // sequence
    // --------------------
    initial begin
        int cnt;
        int n_hold;
        reset   = 1'b1;
        ce      = 1'b0;
        n_valid = 0;
        saw_pos = 1'b0;
        saw_neg = 1'b0;
        rnd     = 32'ha406;
        s1 = SEED0 | 32'h0000_0100;
        s2 = SEED1 | 32'h0000_0100;
        s3 = SEED2 | 32'h0000_0100;
        load_stim();
        if (exp_mag.size() < 41) begin
            abort_run("stimulus file holds too few lines");
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        ce    = 1'b1;

        // pipeline fill, output quiet until the tenth edge
        cnt = 0;
        while (!valid_out && cnt < TIMEOUT) begin
            check_sample(sample, '0, "sample");
            cnt++;
            @(negedge clk);
        end
        if (!valid_out) begin
            abort_run("timed out waiting for first valid_out");
        end
        if (cnt != LATENCY) begin
            abort_run("first valid_out came after the wrong number of cycles");
        end

        // continuous ce
        cnt = 0;
        while (n_valid < 20 && cnt < TIMEOUT) begin
            tick(1'b1);
            cnt++;
        end
        if (n_valid < 20) begin
            abort_run("timed out during continuous run");
        end

        // random ce gaps
        cnt = 0;
        while (n_valid < 40 && cnt < TIMEOUT) begin
            rnd = lcg_next(rnd);
            tick(rnd[31:30] != 2'b00);
            cnt++;
        end
        if (n_valid < 40) begin
            abort_run("timed out during gapped run");
        end

        // long stall, a sample in flight may still land on the first cycle
        tick(1'b0);
        n_hold = n_valid;
        repeat (STALL_N) begin
            tick(1'b0);
        end
        if (n_valid != n_hold) begin
            abort_run("sample appeared during stall");
        end
        cnt = 0;
        while (n_valid == n_hold && cnt < TIMEOUT) begin
            tick(1'b1);
            cnt++;
        end
        if (n_valid == n_hold) begin
            abort_run("timed out waiting for sample after stall");
        end

        if (!(saw_pos && saw_neg)) begin
            abort_run("sample sign never changed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== design/gng_coef.hex ====
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000
200000000000004000

// ==== dv/gng_stim.txt ====
# one expected output magnitude per valid sample, 16-bit hex in s4.11
# the sample is the negated magnitude when the uniform sign bit u[63] is set
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800
0800

// ==== list.f ====
design/gng_pkg.sv
design/gng_coef_pkg.sv
design/gng_urng.sv
design/gng_segment.sv
design/gng_coef_rom.sv
design/gng_smul_sadd.sv
design/gng_poly.sv
design/gng_top.sv
dv/gng_chk.sv
dv/gng_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run from the project root so relative data paths resolve
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        -f list.f --top-module gng_tb -o gng_sim \
    && ./obj_dir/gng_sim \
    || exit 1
